// ==== design/useq_defines.svh ====
// widths shared by the micro sequencer packages and modules
// the micro word and ir layouts in uop_pkg must add up to these sizes
`ifndef USEQ_DEFINES_SVH
`define USEQ_DEFINES_SVH

// ******************************
// micro-ROM geometry
// ******************************

`define MICRO_ADDR_WIDTH 6   // 64 micro words, trap sits at the top
`define MICRO_DATA_WIDTH 50  // one ROM word, see micro_word_t

// ******************************
// expanded micro-op
// ******************************

`define IR_SIZE          36  // packed ir handed to the execution stage
`define DATA_WIDTH       16  // offset and immediate operands

`endif

// ==== design/uop_pkg.sv ====
// types for micro-ROM words and the expanded micro-op stream
// field order follows the ROM bit layout, lowest field declared last
`default_nettype none

`include "useq_defines.svh"

package uop_pkg;

  // ******************************
  // field types
  // ******************************

  typedef logic [`MICRO_ADDR_WIDTH-1:0] micro_addr_t;  // micro-ROM address
  typedef logic [`DATA_WIDTH-1:0]       data_t;        // offset or immediate value
  typedef logic [3:0]                   reg_addr_t;    // register port address
  typedef logic [1:0]                   seg_addr_t;    // segment port address
  typedef logic [3:0]                   ir0_t;         // low opcode field of the ir
  typedef logic [6:0]                   ir1_t;         // high opcode field of the ir
  typedef logic [2:0]                   tsel_t;        // ALU unit select
  typedef logic [2:0]                   func_t;        // function within the unit
  typedef logic [1:0]                   var_sel_t;     // operand substitution select
  typedef logic [2:0]                   imm_sel_t;     // immediate table index

  // ******************************
  // micro-ROM word, 50 bits
  // ******************************

  typedef struct packed {
    logic      end_seq;  // last word of the sequence
    imm_sel_t  var_imm;  // immediate table index
    logic      var_off;  // pass the instruction offset
    var_sel_t  var_d;    // 0 micro_d, 1 dst, else src
    var_sel_t  var_c;    // 0 micro_c, 1 dst, else src
    var_sel_t  var_b;    // 0 micro_b, 1 index, else src
    var_sel_t  var_a;    // 0 micro_a, 1 base, 2 dst, 3 src
    logic      var_s;    // take the segment from the instruction
    ir1_t      ir1;
    func_t     f_rom;    // function unless a flag writing shift overrides it
    tsel_t     t;
    ir0_t      ir0;
    logic      wr_flag;  // word updates the flags
    reg_addr_t micro_d;
    reg_addr_t micro_c;
    reg_addr_t micro_b;
    reg_addr_t micro_a;
    seg_addr_t micro_s;  // bits 1:0
  } micro_word_t;

  // expanded micro instruction, same field order as the execution stage expects
  typedef struct packed {
    ir1_t      ir1;
    func_t     f;
    tsel_t     t;
    ir0_t      ir0;
    logic      wr_flag;
    reg_addr_t addr_d;
    reg_addr_t addr_c;
    reg_addr_t addr_b;
    reg_addr_t addr_a;
    seg_addr_t addr_s;
  } ir_t;

  typedef struct packed {
    ir_t   ir;
    data_t off;
    data_t imm;
    logic  last;  // set on the micro-op from the end_seq word
  } uop_t;

  // ******************************
  // sequence entry points
  // ******************************

  localparam micro_addr_t ENTRY_MOV     = 6'd0;
  localparam micro_addr_t ENTRY_ADD_MEM = 6'd4;
  localparam micro_addr_t ENTRY_SHIFT   = 6'd8;
  localparam micro_addr_t ENTRY_PUSH    = 6'd12;
  localparam micro_addr_t ENTRY_TRAP    = 6'd60;

  localparam tsel_t T_SHIFT = 3'd6;  // shift/rotate unit

endpackage

`default_nettype wire

// ==== design/instr_pkg.sv ====
// types for the decoded instruction handed to the micro sequencer
// opcode values outside the enum are legal and run the trap sequence
`default_nettype none

`include "useq_defines.svh"

package instr_pkg;

  // ******************************
  // operand fields
  // ******************************

  typedef logic [3:0] reg_sel_t;  // general register number
  typedef logic [1:0] seg_sel_t;  // es, cs, ss, ds
  typedef logic [2:0] frot_t;     // rol, ror, rcl, rcr, shl, shr and so on

  typedef enum logic [3:0] {
    OP_MOV     = 4'd0,  // register move with immediate
    OP_ADD_MEM = 4'd1,  // add through a memory operand
    OP_SHIFT   = 4'd2,  // shift/rotate by one
    OP_PUSH    = 4'd3   // push onto the stack
  } opcode_t;

  // ******************************
  // decoded instruction
  // ******************************

  typedef struct packed {
    opcode_t                opcode;
    reg_sel_t               src;
    reg_sel_t               dst;
    reg_sel_t               base;   // address base register
    reg_sel_t               index;  // address index register
    seg_sel_t               seg;
    frot_t                  frot;
    logic [`DATA_WIDTH-1:0] off;    // address displacement
    logic [`DATA_WIDTH-1:0] imm;
  } instr_t;

endpackage

`default_nettype wire

// ==== design/micro_rom.sv ====
// combinational micro-ROM with four sequences and a trap word
// every unlisted address reads as the trap word
`default_nettype none
`timescale 1ns/100ps

module micro_rom (
  input  uop_pkg::micro_addr_t addr_i,
  output uop_pkg::micro_word_t word_o
);

  always_comb begin
    case (addr_i)
      // ******************************
      // MOV, one word
      // ******************************
      6'd0:  word_o = '{ir1: 7'h01, ir0: 4'd1, var_a: 2'd3, var_d: 2'd1,
                        var_imm: 3'd4, end_seq: 1'b1, default: '0};  // a=src, d=dst, imm_i

      // ******************************
      // ADD_MEM, address then add
      // ******************************
      6'd4:  word_o = '{ir1: 7'h02, ir0: 4'd2, var_a: 2'd1, var_b: 2'd1,
                        var_s: 1'b1, var_off: 1'b1, var_imm: 3'd0,
                        default: '0};  // base+index in the instruction segment
      6'd5:  word_o = '{ir1: 7'h03, ir0: 4'd3, var_a: 2'd2, var_c: 2'd2,
                        wr_flag: 1'b1, t: 3'd0, end_seq: 1'b1,
                        default: '0};  // dst plus src with flags

      // ******************************
      // SHIFT, one word
      // ******************************
      6'd8:  word_o = '{ir1: 7'h04, ir0: 4'd4, t: 3'd6, f_rom: 3'd4,
                        wr_flag: 1'b1, var_a: 2'd2, var_imm: 3'd7,
                        end_seq: 1'b1, default: '0};  // f replaced by frot downstream

      // ******************************
      // PUSH, three words
      // ******************************
      6'd12: word_o = '{ir1: 7'h05, ir0: 4'd5, micro_a: 4'd4, micro_s: 2'd2,
                        var_imm: 3'd1, default: '0};  // sp step of 2 in ss
      6'd13: word_o = '{ir1: 7'h06, ir0: 4'd6, micro_a: 4'd4, var_b: 2'd2,
                        var_imm: 3'd5, default: '0};  // src with an all ones mask
      6'd14: word_o = '{ir1: 7'h07, ir0: 4'd7, micro_d: 4'd4, var_imm: 3'd6,
                        end_seq: 1'b1, default: '0};  // sp write back, imm 3

      // trap word, also at ENTRY_TRAP, selects nothing from the instruction
      default: word_o = '{ir0: 4'd15, end_seq: 1'b1, default: '0};
    endcase
  end

endmodule

`default_nettype wire

// ==== design/micro_data.sv ====
// expands the addressed micro word with instruction operands
// purely combinational, so the uop follows n_micro_i in the same cycle
`default_nettype none
`timescale 1ns/100ps

`include "useq_defines.svh"

module micro_data (
  input  uop_pkg::micro_addr_t n_micro_i,
  input  instr_pkg::instr_t    instr_i,
  output uop_pkg::uop_t        uop_o,
  output logic                 end_seq_o
);

  uop_pkg::micro_word_t word;    // raw ROM word for this step
  uop_pkg::ir_t         ir;      // word after operand substitution
  uop_pkg::data_t       imm_sel; // value picked from the immediate table

  // layouts in uop_pkg have to match the widths the core was built for
  if ($bits(uop_pkg::micro_word_t) != `MICRO_DATA_WIDTH) begin : g_word_width_err
    $error("micro word layout does not match MICRO_DATA_WIDTH");
  end
  if ($bits(uop_pkg::ir_t) != `IR_SIZE) begin : g_ir_width_err
    $error("ir layout does not match IR_SIZE");
  end

  micro_rom u_rom (
    .addr_i (n_micro_i),
    .word_o (word)
  );

  // ******************************
  // operand substitution
  // ******************************

  always_comb begin
    case (word.var_a)
      2'd0:    ir.addr_a = word.micro_a;  // fixed register from the ROM
      2'd1:    ir.addr_a = instr_i.base;
      2'd2:    ir.addr_a = instr_i.dst;
      default: ir.addr_a = instr_i.src;
    endcase
    case (word.var_b)
      2'd0:    ir.addr_b = word.micro_b;
      2'd1:    ir.addr_b = instr_i.index;
      default: ir.addr_b = instr_i.src;
    endcase
    ir.addr_c  = (word.var_c == 2'd0) ? word.micro_c   // c and d share one encoding
               : (word.var_c == 2'd1) ? instr_i.dst : instr_i.src;
    ir.addr_d  = (word.var_d == 2'd0) ? word.micro_d
               : (word.var_d == 2'd1) ? instr_i.dst : instr_i.src;
    ir.addr_s  = word.var_s ? instr_i.seg : word.micro_s;
    ir.wr_flag = word.wr_flag;
    ir.ir0     = word.ir0;
    ir.t       = word.t;
    ir.ir1     = word.ir1;
    // flag writing shifts take their function from the instruction
    ir.f       = (word.t == uop_pkg::T_SHIFT && word.wr_flag) ? instr_i.frot : word.f_rom;
  end

  // ******************************
  // immediate and offset
  // ******************************

  always_comb begin
    case (word.var_imm)
      3'd0:    imm_sel = 16'h0000;
      3'd1:    imm_sel = 16'h0002;     // word step
      3'd2:    imm_sel = 16'h0004;     // dword step
      3'd3:    imm_sel = instr_i.off;
      3'd4:    imm_sel = instr_i.imm;
      3'd5:    imm_sel = 16'hffff;
      3'd6:    imm_sel = 16'h0003;
      default: imm_sel = 16'h0001;     // shift count of one
    endcase
  end

  assign uop_o.ir   = ir;
  assign uop_o.off  = word.var_off ? instr_i.off : '0;  // zero unless the word asks for it
  assign uop_o.imm  = imm_sel;
  assign uop_o.last = word.end_seq;
  assign end_seq_o  = word.end_seq;  // back to the sequencer

endmodule

`default_nettype wire

// ==== design/micro_seq.sv ====
// input side of the sequencer, one instruction held at a time
// a new instruction is taken in the cycle the previous end word issues
// the address steps only on issue, so it holds under back-pressure
`default_nettype none
`timescale 1ns/100ps

module micro_seq (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  instr_pkg::instr_t    in_instr_i,
  input  logic                 end_seq_i,
  input  logic                 issue_ready_i,
  output logic                 issue_valid_o,
  output uop_pkg::micro_addr_t n_micro_o,
  output instr_pkg::instr_t    instr_o
);

  typedef enum logic {
    IDLE,  // nothing held, ready for an instruction
    RUN    // stepping through the held instruction's words
  } seq_state_e;

  seq_state_e state_q;
  logic       accept;    // instruction handshake this cycle
  logic       issue;     // current word goes to the buffer
  logic       last_issue; // the end word goes this cycle

  // maps an opcode to its first ROM word, unknown ones trap
  function automatic uop_pkg::micro_addr_t entry_of(instr_pkg::opcode_t op);
    case (op)
      instr_pkg::OP_MOV:     return uop_pkg::ENTRY_MOV;
      instr_pkg::OP_ADD_MEM: return uop_pkg::ENTRY_ADD_MEM;
      instr_pkg::OP_SHIFT:   return uop_pkg::ENTRY_SHIFT;
      instr_pkg::OP_PUSH:    return uop_pkg::ENTRY_PUSH;
      default:               return uop_pkg::ENTRY_TRAP;
    endcase
  endfunction

  // ******************************
  // handshakes
  // ******************************

  assign issue_valid_o = (state_q == RUN);
  assign issue         = issue_valid_o && issue_ready_i;
  assign last_issue    = issue && end_seq_i;
  assign in_ready_o    = (state_q == IDLE) || last_issue;  // no bubble between sequences
  assign accept        = in_valid_i && in_ready_o;

  // ******************************
  // state and micro address
  // ******************************

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= IDLE;
      n_micro_o <= '0;
    end else if (accept) begin
      state_q   <= RUN;                        // also covers the overlap with last_issue
      n_micro_o <= entry_of(in_instr_i.opcode);
    end else if (last_issue) begin
      state_q   <= IDLE;                       // address left on the end word
    end else if (issue) begin
      n_micro_o <= n_micro_o + 1'b1;          // words of a sequence are consecutive
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      instr_o <= in_instr_i;  // operands stay put until the sequence ends
    end
  end

  // ******************************
  // assertions
  // ******************************

  // a stalled word must present the same operands on the next cycle
  a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    issue_valid_o && !issue_ready_i |=> $stable(n_micro_o) && $stable(instr_o));

  // a word that is not the last one is followed by the next address with the same operands
  a_run_accept: assert property (@(posedge clk) disable iff (!rst_n_i)
    issue && !end_seq_i |=> n_micro_o == $past(n_micro_o) + 1'b1 && $stable(instr_o));

endmodule

`default_nettype wire

// ==== design/uop_out_buf.sv ====
// two-entry registered buffer between the expander and the consumer
// ready depends on the fill count only, not on out_ready_i
`default_nettype none
`timescale 1ns/100ps

module uop_out_buf (
  input  logic          clk,
  input  logic          rst_n_i,
  input  logic          in_valid_i,
  output logic          in_ready_o,
  input  uop_pkg::uop_t in_uop_i,
  output logic          out_valid_o,
  input  logic          out_ready_i,
  output uop_pkg::uop_t out_uop_o
);

  uop_pkg::uop_t mem [2];  // entry storage, written at wr_ptr
  logic          wr_ptr;
  logic          rd_ptr;
  logic [1:0]    count;    // 0 to 2 entries held
  logic          wr_en;
  logic          rd_en;

  assign in_ready_o  = (count != 2'd2);  // at least one entry free
  assign out_valid_o = (count != 2'd0);
  assign out_uop_o   = mem[rd_ptr];      // head of the queue
  assign wr_en       = in_valid_i && in_ready_o;
  assign rd_en       = out_valid_o && out_ready_i;

  // ******************************
  // pointers and fill count
  // ******************************

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (wr_en) wr_ptr <= ~wr_ptr;
      if (rd_en) rd_ptr <= ~rd_ptr;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;  // both or neither keep the level
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_uop_i;
    end
  end

  // a full, stalled buffer keeps its head, so nothing overwrote it
  a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n_i)
    count == 2'd2 && !out_ready_i |=> count == 2'd2 && $stable(out_uop_o));

endmodule

`default_nettype wire

// ==== design/useq_top.sv ====
// microcode front end, sequencer feeding expander feeding output buffer
// first uop reaches the output two cycles after the instruction handshake
`default_nettype none
`timescale 1ns/100ps

module useq_top (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  instr_pkg::instr_t in_instr_i,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output uop_pkg::uop_t     out_uop_o
);

  uop_pkg::micro_addr_t n_micro;     // current ROM address
  instr_pkg::instr_t    instr;       // held instruction operands
  uop_pkg::uop_t        uop;         // expanded word on its way to the buffer
  logic                 issue_valid;
  logic                 issue_ready;
  logic                 end_seq;

  micro_seq u_seq (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .in_instr_i    (in_instr_i),
    .end_seq_i     (end_seq),
    .issue_ready_i (issue_ready),
    .issue_valid_o (issue_valid),
    .n_micro_o     (n_micro),
    .instr_o       (instr)
  );

  micro_data u_data (
    .n_micro_i (n_micro),
    .instr_i   (instr),
    .uop_o     (uop),
    .end_seq_o (end_seq)
  );

  uop_out_buf u_buf (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (issue_valid),
    .in_ready_o  (issue_ready),
    .in_uop_i    (uop),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_uop_o   (out_uop_o)
  );

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
// free running clock for the testbench, starts low at time zero
`default_nettype none
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 8  // full period, kept even so both halves match
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(PERIOD_NS / 2) clk_o = ~clk_o;  // toggles every half period

endmodule

`default_nettype wire

// ==== dv/useq_tb.sv ====
// directed tests for useq_top, inputs change on the falling edge
// expected uops come from the documented ROM sequences kept below
// the watchdog limit scales with NUM_INSTR, keep it in step with the tests
`default_nettype none
`timescale 1ns/100ps

module useq_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_INSTR    = 61;  // every instruction the tests below send

  logic              clk;
  logic              rst_n;
  logic              in_valid;
  logic              in_ready;
  instr_pkg::instr_t in_instr;
  logic              out_valid;
  logic              out_ready;
  uop_pkg::uop_t     out_uop;

  uop_pkg::uop_t exp_q[$];  // expected uops in order
  uop_pkg::uop_t got_q[$];  // uops taken by the consumer
  time           got_t[$];  // edge time of each output handshake
  time           acc_t[$];  // edge time of each input handshake
  int            mismatch_errs;
  int            other_errs;
  logic          stall_en;  // random out_ready when set

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk (.clk_o(clk));

  useq_top uut (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .in_instr_i  (in_instr),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .out_uop_o   (out_uop)
  );

  // ******************************
  // reference model
  // ******************************

  function automatic uop_pkg::uop_t make_uop(
    input uop_pkg::ir1_t ir1, input uop_pkg::ir0_t ir0, input uop_pkg::tsel_t t,
    input uop_pkg::func_t f, input logic wr,
    input uop_pkg::reg_addr_t a, input uop_pkg::reg_addr_t b,
    input uop_pkg::reg_addr_t c, input uop_pkg::reg_addr_t d,
    input uop_pkg::seg_addr_t s, input uop_pkg::data_t off,
    input uop_pkg::data_t imm, input logic last);
    uop_pkg::uop_t u;
    u            = '0;
    u.ir.ir1     = ir1;
    u.ir.ir0     = ir0;
    u.ir.t       = t;
    u.ir.f       = f;
    u.ir.wr_flag = wr;
    u.ir.addr_a  = a;
    u.ir.addr_b  = b;
    u.ir.addr_c  = c;
    u.ir.addr_d  = d;
    u.ir.addr_s  = s;
    u.off        = off;
    u.imm        = imm;
    u.last       = last;
    return u;
  endfunction

  // appends the uops one instruction should produce
  task automatic expect_instr(input instr_pkg::instr_t ins);
    case (ins.opcode)
      instr_pkg::OP_MOV:
        exp_q.push_back(make_uop(7'h01, 4'd1, 3'd0, 3'd0, 1'b0, ins.src, 4'd0, 4'd0,
                                 ins.dst, 2'd0, 16'h0000, ins.imm, 1'b1));
      instr_pkg::OP_ADD_MEM: begin
        exp_q.push_back(make_uop(7'h02, 4'd2, 3'd0, 3'd0, 1'b0, ins.base, ins.index,
                                 4'd0, 4'd0, ins.seg, ins.off, 16'h0000, 1'b0));
        exp_q.push_back(make_uop(7'h03, 4'd3, 3'd0, 3'd0, 1'b1, ins.dst, 4'd0, ins.src,
                                 4'd0, 2'd0, 16'h0000, 16'h0000, 1'b1));
      end
      instr_pkg::OP_SHIFT:  // f comes from the rotate field
        exp_q.push_back(make_uop(7'h04, 4'd4, 3'd6, ins.frot, 1'b1, ins.dst, 4'd0, 4'd0,
                                 4'd0, 2'd0, 16'h0000, 16'h0001, 1'b1));
      instr_pkg::OP_PUSH: begin
        exp_q.push_back(make_uop(7'h05, 4'd5, 3'd0, 3'd0, 1'b0, 4'd4, 4'd0, 4'd0, 4'd0,
                                 2'd2, 16'h0000, 16'h0002, 1'b0));
        exp_q.push_back(make_uop(7'h06, 4'd6, 3'd0, 3'd0, 1'b0, 4'd4, ins.src, 4'd0, 4'd0,
                                 2'd0, 16'h0000, 16'hffff, 1'b0));
        exp_q.push_back(make_uop(7'h07, 4'd7, 3'd0, 3'd0, 1'b0, 4'd0, 4'd0, 4'd0, 4'd4,
                                 2'd0, 16'h0000, 16'h0003, 1'b1));
      end
      default:  // trap word, nothing taken from the instruction
        exp_q.push_back(make_uop(7'h00, 4'd15, 3'd0, 3'd0, 1'b0, 4'd0, 4'd0, 4'd0, 4'd0,
                                 2'd0, 16'h0000, 16'h0000, 1'b1));
    endcase
  endtask

  function automatic instr_pkg::instr_t rand_instr(input logic [3:0] op);
    instr_pkg::instr_t ins;
    ins.opcode = instr_pkg::opcode_t'(op);
    ins.src    = 4'($urandom);
    ins.dst    = 4'($urandom);
    ins.base   = 4'($urandom);
    ins.index  = 4'($urandom);
    ins.seg    = 2'($urandom);
    ins.frot   = 3'($urandom);
    ins.off    = 16'($urandom);
    ins.imm    = 16'($urandom);
    return ins;
  endfunction

  // mostly documented opcodes, one in five an unknown one
  function automatic logic [3:0] pick_opcode();
    int r;
    r = $urandom % 5;
    return (r < 4) ? 4'(r) : 4'(8 + $urandom % 8);
  endfunction

  // ******************************
  // compare tasks
  // ******************************

  task automatic check_uop(input uop_pkg::uop_t got, input uop_pkg::uop_t exp,
                           input string tag, input int idx);
    if (got !== exp) begin
      mismatch_errs++;
      $display("MISMATCH out_uop_o (%s, uop %0d): got %h expected %h", tag, idx, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      mismatch_errs++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  // ******************************
  // drivers and consumer
  // ******************************

  // holds in_valid until the sequencer takes the instruction
  task automatic push_instr(input instr_pkg::instr_t ins);
    @(negedge clk);
    in_valid = 1'b1;
    in_instr = ins;
    expect_instr(ins);
    @(posedge clk);
    while (!in_ready) @(posedge clk);
    acc_t.push_back($time);
  endtask

  task automatic release_input();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // waits for every expected uop, then a few cycles more to catch extras
  task automatic drain_and_compare(input string tag);
    int n;
    while (got_q.size() < exp_q.size()) @(negedge clk);
    repeat (4) @(negedge clk);
    if (got_q.size() != exp_q.size()) begin
      other_errs++;
      $display("%s: received %0d uops but expected %0d", tag, got_q.size(), exp_q.size());
    end
    n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
    for (int i = 0; i < n; i++) check_uop(got_q[i], exp_q[i], tag, i);
    exp_q.delete();
    got_q.delete();
    got_t.delete();
    acc_t.delete();
  endtask

  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      got_q.push_back(out_uop);
      got_t.push_back($time);
    end
  end

  always @(negedge clk) begin
    out_ready = stall_en ? ($urandom % 3 != 0) : 1'b1;  // stalls about a third of cycles
  end

  // ******************************
  // directed tests
  // ******************************

  task automatic state_after_reset();
    @(negedge clk);
    check_bit(out_valid, 1'b0, "out_valid_o");
    check_bit(in_ready, 1'b1, "in_ready_o");
  endtask

  task automatic mov_add_operands();
    for (int i = 0; i < 4; i++) begin
      push_instr(rand_instr(4'(instr_pkg::OP_MOV)));
      push_instr(rand_instr(4'(instr_pkg::OP_ADD_MEM)));
      release_input();
      drain_and_compare("mov_add");
    end
  endtask

  task automatic shift_functions();
    instr_pkg::instr_t ins;
    for (int f = 0; f < 8; f++) begin
      ins      = rand_instr(4'(instr_pkg::OP_SHIFT));
      ins.frot = 3'(f);
      push_instr(ins);
      release_input();
      drain_and_compare("shift");
    end
  endtask

  task automatic push_and_trap();
    push_instr(rand_instr(4'(instr_pkg::OP_PUSH)));
    push_instr(rand_instr(4'ha));  // no sequence for this opcode
    release_input();
    drain_and_compare("push_trap");
  endtask

  task automatic random_stream_stalls();
    stall_en = 1'b1;
    for (int i = 0; i < 40; i++) begin
      push_instr(rand_instr(pick_opcode()));
      if ($urandom % 4 == 0) release_input();  // idle gap now and then
    end
    release_input();
    drain_and_compare("random_stream");
    stall_en = 1'b0;
  endtask

  // three single word MOVs back to back with the consumer always ready
  task automatic latency_and_throughput();
    for (int i = 0; i < 3; i++) push_instr(rand_instr(4'(instr_pkg::OP_MOV)));
    release_input();
    while (got_t.size() < 3) @(negedge clk);
    if (got_t[0] - acc_t[0] != 2 * CLK_PERIOD) begin
      other_errs++;
      $display("first uop came %0t ns after the handshake instead of two cycles",
               got_t[0] - acc_t[0]);
    end
    for (int i = 1; i < 3; i++) begin
      if (acc_t[i] - acc_t[i-1] != CLK_PERIOD) begin
        other_errs++;
        $display("instruction %0d was not accepted in the cycle after the previous one", i);
      end
      if (got_t[i] - got_t[i-1] != CLK_PERIOD) begin
        other_errs++;
        $display("uop %0d did not follow the previous uop in the next cycle", i);
      end
    end
    drain_and_compare("latency");
  endtask

  // ******************************
  // run control
  // ******************************

  initial begin
    rst_n         = 1'b0;
    in_valid      = 1'b0;
    in_instr      = '0;
    out_ready     = 1'b1;
    stall_en      = 1'b0;
    mismatch_errs = 0;
    other_errs    = 0;
    void'($urandom(55));
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    state_after_reset();
    mov_add_operands();
    shift_functions();
    push_and_trap();
    random_stream_stalls();
    latency_and_throughput();
    $display("closing count: %0d mismatches, %0d other errors", mismatch_errs, other_errs);
    if (mismatch_errs + other_errs == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // 200 cycles per instruction is far above the longest stalled sequence
  initial begin
    #((NUM_INSTR * 200 + RESET_CYCLES) * CLK_PERIOD);
    other_errs++;
    $display("watchdog expired before the tests finished, the DUT stopped responding");
    $display("closing count: %0d mismatches, %0d other errors", mismatch_errs, other_errs);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== useq.f ====
+incdir+design
design/uop_pkg.sv
design/instr_pkg.sv
design/micro_rom.sv
design/micro_data.sv
design/micro_seq.sv
design/uop_out_buf.sv
design/useq_top.sv
dv/tb_clk_gen.sv
dv/useq_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the useq testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f useq.f \
  --top-module useq_tb \
  --Mdir obj_dir \
  -o useq_sim

./obj_dir/useq_sim | tee sim.log

# the testbench prints the pass line only when every check held
if grep -qx "No errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
